//--- acPkg.sv
package acPkg;

	//////////////////////////////////////////////////////////////////////
	// Frame geometry
	//////////////////////////////////////////////////////////////////////

	// Samples per frame and number of correlation lags
	localparam int frameLen = 240;
	localparam int numLags  = 11;

	// Q15 rounding for the window product
	localparam int roundBias = 16384;
	localparam int q15Shift  = 15;

	//////////////////////////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////////////////////////

	// Speech samples and window coefficients
	typedef logic signed [15:0] sampleT;
	// Sample memory address
	typedef logic [7:0] addrT;
	// Result index, 0 to 10
	typedef logic [3:0] lagT;
	// Wide accumulator, headroom for 240 full-scale products
	typedef logic signed [39:0] accT;
	// One r value as written out
	typedef logic signed [31:0] corrT;

	// Last addresses of each sequence
	localparam addrT lastAddr = addrT'(frameLen - 1);
	localparam lagT  lastLag  = lagT'(numLags - 1);

	// Saturation bounds
	localparam sampleT sampleMax = 16'sh7FFF;
	localparam sampleT sampleMin = 16'sh8000;
	localparam corrT   corrMax   = 32'sh7FFF_FFFF;
	localparam corrT   corrMin   = 32'sh8000_0000;

	// One sample beat broadcast to every correlator
	typedef struct packed {
		logic   valid;
		logic   first;
		sampleT cur;
	} corrBeatT;

	// Sequencer states
	typedef enum logic [1:0] {wIdle, wRun, wWait} windowStateT;
	typedef enum logic [1:0] {fIdle, fRun, fDrain} feedStateT;
	typedef enum logic [1:0] {dIdle, dRun, dDone} drainStateT;

endpackage

//--- windowUnit.sv
module windowUnit import acPkg::*; (
	input  logic   mclk,
	input  logic   rstN,
	input  logic   ready,
	input  logic   done,
	input  sampleT xIn,
	input  sampleT winIn,
	output addrT   xReq,
	output addrT   yWriteReq,
	output sampleT yOut,
	output logic   yWrite,
	output logic   windowDone
);

	windowStateT state;
	addrT addr;
	// Full Q30 product and its rounded Q15 value before saturation
	logic signed [31:0] prod;
	logic signed [31:0] rounded;

	// Read and write share one address, y[n] lands where x[n] came from
	assign xReq      = addr;
	assign yWriteReq = addr;
	assign yWrite    = (state == wRun);

	//////////////////////////////////////////////////////////////////////
	// Windowing datapath
	//////////////////////////////////////////////////////////////////////

	assign prod    = xIn * winIn;
	// Round to nearest, then back to Q15
	assign rounded = (prod + roundBias) >>> q15Shift;

	// Only -1 * -1 can overflow, clamp both ends anyway
	always_comb begin
		if (rounded > sampleMax)
			yOut = sampleMax;
		else if (rounded < sampleMin)
			yOut = sampleMin;
		else
			yOut = sampleT'(rounded);
	end

	//////////////////////////////////////////////////////////////////////
	// Phase-one sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mclk) begin
		if (!rstN) begin
			state      <= wIdle;
			addr       <= '0;
			windowDone <= 1'b0;
		end else begin
			// Pulse one cycle after the write of sample 239
			windowDone <= (state == wRun) && (addr == lastAddr);
			case (state)
				wIdle: begin
					addr <= '0;
					if (ready)
						state <= wRun;
				end
				wRun: begin
					addr <= addr + addrT'(1);
					if (addr == lastAddr)
						state <= wWait;
				end
				// Busy until the drain finishes, ready ignored here
				wWait: begin
					if (done)
						state <= wIdle;
				end
				default: state <= wIdle;
			endcase
		end
	end

endmodule

//--- lagFeeder.sv
module lagFeeder import acPkg::*; (
	input  logic                  mclk,
	input  logic                  rstN,
	input  logic                  windowDone,
	input  sampleT                yIn,
	output addrT                  yReadReq,
	output corrBeatT              beat,
	output sampleT [numLags-1:0]  taps,
	output logic                  sumsReady
);

	feedStateT state;
	addrT addr;

	assign yReadReq = addr;

	//////////////////////////////////////////////////////////////////////
	// Phase-two read sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mclk) begin
		if (!rstN) begin
			state     <= fIdle;
			addr      <= '0;
			sumsReady <= 1'b0;
		end else begin
			// Last beat is accumulated at the end of fDrain
			sumsReady <= (state == fDrain);
			case (state)
				fIdle: begin
					addr <= '0;
					if (windowDone)
						state <= fRun;
				end
				fRun: begin
					addr <= addr + addrT'(1);
					if (addr == lastAddr)
						state <= fDrain;
				end
				// Final beat in flight to the correlators
				fDrain: state <= fIdle;
				default: state <= fIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Beat register and delay line
	//////////////////////////////////////////////////////////////////////

	// One beat per read, registered so y lookup and MAC sit in separate cycles
	always_ff @(posedge mclk) begin
		if (!rstN) begin
			beat <= '0;
		end else begin
			beat.valid <= (state == fRun);
			beat.first <= (state == fRun) && (addr == '0);
			beat.cur   <= yIn;
		end
	end

	// taps[k] tracks y[n-k] for the beat currently presented
	// Cleared at frame start so lags before sample 0 multiply by zero
	always_ff @(posedge mclk) begin
		if (state == fIdle && windowDone)
			taps <= '0;
		else if (state == fRun)
			taps <= {taps[numLags-2:0], yIn};
	end

endmodule

//--- lagCorrelator.sv
module lagCorrelator import acPkg::*; (
	input  logic     mclk,
	input  logic     rstN,
	input  corrBeatT beat,
	input  sampleT   tap,
	output corrT     r
);

	accT acc;
	// y[n] * y[n-k], exact in 32 bits
	logic signed [31:0] prod;
	// Accumulator times two, one guard bit
	logic signed [$bits(accT):0] dbl;

	assign prod = beat.cur * tap;

	//////////////////////////////////////////////////////////////////////
	// Multiply-accumulate
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mclk) begin
		if (!rstN) begin
			acc <= '0;
		end else if (beat.valid) begin
			// First beat of a frame restarts the sum
			if (beat.first)
				acc <= accT'(prod);
			else
				acc <= acc + accT'(prod);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output scaling
	//////////////////////////////////////////////////////////////////////

	assign dbl = {acc, 1'b0};

	// Held until the next first beat, drain reads it at leisure
	always_comb begin
		if (dbl > corrMax)
			r = corrMax;
		else if (dbl < corrMin)
			r = corrMin;
		else
			r = corrT'(dbl);
	end

endmodule

//--- resultDrain.sv
module resultDrain import acPkg::*; (
	input  logic               mclk,
	input  logic               rstN,
	input  logic               sumsReady,
	input  corrT [numLags-1:0] rAll,
	output lagT                rReq,
	output corrT               rOut,
	output logic               rWrite,
	output logic               done
);

	drainStateT state;
	lagT idx;

	// One result per cycle straight from the selected correlator
	assign rReq   = idx;
	assign rOut   = rAll[idx];
	assign rWrite = (state == dRun);
	// Frame end, also releases the window sequencer
	assign done   = (state == dDone);

	//////////////////////////////////////////////////////////////////////
	// Drain sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge mclk) begin
		if (!rstN) begin
			state <= dIdle;
			idx   <= '0;
		end else begin
			case (state)
				dIdle: begin
					idx <= '0;
					if (sumsReady)
						state <= dRun;
				end
				// Lags 0 to 10 back to back
				dRun: begin
					idx <= idx + lagT'(1);
					if (idx == lastLag)
						state <= dDone;
				end
				dDone: state <= dIdle;
				default: state <= dIdle;
			endcase
		end
	end

endmodule

//--- autoCorr.sv
module autoCorr import acPkg::*; (
	input  logic   mclk,
	input  logic   rstN,
	input  logic   ready,
	input  sampleT xIn,
	input  sampleT winIn,
	input  sampleT yIn,
	output addrT   xReq,
	output addrT   yReadReq,
	output addrT   yWriteReq,
	output sampleT yOut,
	output logic   yWrite,
	output lagT    rReq,
	output corrT   rOut,
	output logic   rWrite,
	output logic   done
);

	// Phase one to phase two handover
	logic windowDone;
	// Broadcast beat and per-lag delayed samples
	corrBeatT beat;
	sampleT [numLags-1:0] taps;
	// Correlation results and their ready strobe
	logic sumsReady;
	corrT [numLags-1:0] rAll;

	//////////////////////////////////////////////////////////////////////
	// Phase one, windowing
	//////////////////////////////////////////////////////////////////////

	windowUnit uWindow (
		.mclk       (mclk),
		.rstN       (rstN),
		.ready      (ready),
		.done       (done),
		.xIn        (xIn),
		.winIn      (winIn),
		.xReq       (xReq),
		.yWriteReq  (yWriteReq),
		.yOut       (yOut),
		.yWrite     (yWrite),
		.windowDone (windowDone)
	);

	//////////////////////////////////////////////////////////////////////
	// Phase two, correlation
	//////////////////////////////////////////////////////////////////////

	lagFeeder uFeeder (
		.mclk       (mclk),
		.rstN       (rstN),
		.windowDone (windowDone),
		.yIn        (yIn),
		.yReadReq   (yReadReq),
		.beat       (beat),
		.taps       (taps),
		.sumsReady  (sumsReady)
	);

	// All lags run in parallel on the same beat
	for (genvar k = 0; k < numLags; k++) begin : gLag
		lagCorrelator uCorr (
			.mclk (mclk),
			.rstN (rstN),
			.beat (beat),
			.tap  (taps[k]),
			.r    (rAll[k])
		);
	end

	// Results out, one lag per cycle
	resultDrain uDrain (
		.mclk      (mclk),
		.rstN      (rstN),
		.sumsReady (sumsReady),
		.rAll      (rAll),
		.rReq      (rReq),
		.rOut      (rOut),
		.rWrite    (rWrite),
		.done      (done)
	);

endmodule

//--- acChecker.sv
module acChecker import acPkg::*; (
	input logic                    mclk,
	input logic                    rstN,
	input logic                    ready,
	input sampleT [frameLen-1:0]   xArr,
	input sampleT [frameLen-1:0]   winArr,
	input addrT                    xReq,
	input addrT                    yReadReq,
	input addrT                    yWriteReq,
	input sampleT                  yOut,
	input logic                    yWrite,
	input lagT                     rReq,
	input corrT                    rOut,
	input logic                    rWrite,
	input logic                    done
);

	int errCount   = 0;
	int missCount  = 0;
	int frameCount = 0;
	// Frame bookkeeping, opened by the accepted ready
	bit frameOpen = 1'b0;
	int yIdx = 0;
	int rIdx = 0;
	// Next y address expected from the phase-two reads
	int rdIdx = 0;
	// Expected y of the current frame, source for the r reference
	sampleT [frameLen-1:0] yExp;
	corrT rWant;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Q15 product, round half up, clamp to 16 bits
	function automatic sampleT windowRef(input sampleT xs, input sampleT ws);
		longint p;
		p = (longint'(xs) * longint'(ws) + 64'sd16384) >>> 15;
		if (p > 64'sd32767)
			return 16'sh7FFF;
		else if (p < -64'sd32768)
			return 16'sh8000;
		else
			return sampleT'(p);
	endfunction

	// Exact lag sum, doubled, clamped to 32 bits
	function automatic corrT lagRef(input sampleT [frameLen-1:0] ys, input int k);
		longint acc;
		int n;
		acc = 0;
		for (n = k; n < frameLen; n++)
			acc += longint'($signed(ys[n])) * longint'($signed(ys[n-k]));
		acc = acc * 2;
		if (acc > 64'sd2147483647)
			return 32'sh7FFF_FFFF;
		else if (acc < -64'sd2147483648)
			return 32'sh8000_0000;
		else
			return corrT'(acc);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Port monitors
	//////////////////////////////////////////////////////////////////////

	task automatic checkYWrite();
		if (yIdx >= frameLen) begin
			$display("Extra y write at time %0t, frame already had %0d", $time, frameLen);
			errCount++;
		end else begin
			yExp[yIdx] = windowRef(xArr[yIdx], winArr[yIdx]);
			if (xReq !== addrT'(yIdx)) begin
				$display("ERR %0t: x read address %0d, expected %0d", $time, xReq, yIdx);
				errCount++;
			end
			if (yWriteReq !== addrT'(yIdx)) begin
				$display("ERR %0t: y write address %0d, expected %0d", $time, yWriteReq, yIdx);
				errCount++;
			end
			if (yOut !== yExp[yIdx]) begin
				$display("ERR %0t: y[%0d] = %0d, expected %0d", $time, yIdx,
					$signed(yOut), $signed(yExp[yIdx]));
				errCount++;
			end
			yIdx++;
		end
	endtask

	// Phase-two reads walk y upward from 0, a repeated address is a hold
	task automatic checkYRead();
		if (rdIdx < frameLen) begin
			if (yReadReq === addrT'(rdIdx))
				rdIdx++;
			else if (rdIdx == 0 || yReadReq !== addrT'(rdIdx - 1)) begin
				$display("ERR %0t: y read address %0d, expected %0d", $time, yReadReq, rdIdx);
				errCount++;
			end
		end
	endtask

	task automatic checkRWrite();
		if (rIdx >= numLags) begin
			$display("Extra r write at time %0t, frame already had %0d", $time, numLags);
			errCount++;
		end else begin
			if (rIdx == 0 && yIdx != frameLen) begin
				$display("r writes began at time %0t after only %0d y writes", $time, yIdx);
				errCount++;
			end
			rWant = lagRef(yExp, rIdx);
			if (rReq !== lagT'(rIdx)) begin
				$display("ERR %0t: r write index %0d, expected %0d", $time, rReq, rIdx);
				errCount++;
			end
			if (rOut !== rWant) begin
				$display("ERR %0t: r[%0d] = %0d, expected %0d", $time, rIdx,
					$signed(rOut), $signed(rWant));
				errCount++;
			end
			rIdx++;
		end
	endtask

	task automatic closeFrame();
		if (yIdx < frameLen || rIdx < numLags) begin
			$display("Frame %0d ended with %0d of %0d y writes and %0d of %0d r writes",
				frameCount, yIdx, frameLen, rIdx, numLags);
			missCount += (frameLen - yIdx) + (numLags - rIdx);
		end
		if (rdIdx < frameLen) begin
			$display("Frame %0d read y only up to address %0d before the results",
				frameCount, rdIdx);
			errCount++;
		end
		frameCount++;
		frameOpen = 1'b0;
	endtask

	// Sampled on the rising edge, same instant the memories capture
	always @(posedge mclk) begin
		if (!rstN) begin
			frameOpen = 1'b0;
			yIdx = 0;
			rIdx = 0;
			rdIdx = 0;
		end else begin
			// Strobes are quiet outside a frame, second done caught here too
			if (!frameOpen && (yWrite !== 1'b0 || rWrite !== 1'b0 || done !== 1'b0)) begin
				$display("Output strobe active at time %0t with no frame started", $time);
				errCount++;
			end
			// Read window between the last y write and the first r write
			if (frameOpen && yIdx == frameLen && rIdx == 0 && rWrite !== 1'b1)
				checkYRead();
			if (frameOpen && yWrite === 1'b1)
				checkYWrite();
			if (frameOpen && rWrite === 1'b1)
				checkRWrite();
			if (frameOpen && done === 1'b1) begin
				closeFrame();
			end else if (!frameOpen && ready === 1'b1) begin
				// Edge E, ready while open is ignored
				frameOpen = 1'b1;
				yIdx = 0;
				rIdx = 0;
				rdIdx = 0;
			end
		end
	end

	// End of run summary, one line with all counts
	task automatic finalCheck(input int expFrames, output bit ok);
		if (frameCount != expFrames)
			$display("Expected %0d frames to complete, %0d did", expFrames, frameCount);
		$display("Checker summary: %0d errors, %0d missing writes, %0d frames",
			errCount, missCount, frameCount);
		ok = (errCount == 0) && (missCount == 0) && (frameCount == expFrames) && !frameOpen;
	endtask

endmodule

//--- tbAutoCorr.sv
module tbAutoCorr import acPkg::*; ();

	localparam int resetCycles = 10;
	localparam int quietCycles = 20;
	localparam int numFrames   = 6;
	// Window pass, read pass, drain and a few idle cycles
	localparam int frameCycles = 2 * frameLen + numLags + 8;
	// All frames plus reset with a third of margin, about 4000
	localparam int timeoutCycles = (resetCycles + quietCycles + numFrames * frameCycles) * 4 / 3;

	// Frame contents
	localparam int kindRandom = 0;
	localparam int kindSat    = 1;
	localparam int kindZero   = 2;

	logic   mclk = 1'b0;
	logic   rstN;
	logic   ready;
	sampleT xIn, winIn, yIn, yOut;
	addrT   xReq, yReadReq, yWriteReq;
	logic   yWrite, rWrite, done;
	lagT    rReq;
	corrT   rOut;

	// x, window and y memories
	sampleT [frameLen-1:0] xMem;
	sampleT [frameLen-1:0] winMem;
	sampleT [frameLen-1:0] yMem;

	integer seed;
	int cycleCount = 0;
	bit runOk;

	always #10 mclk = ~mclk;

	//////////////////////////////////////////////////////////////////////
	// Memory models
	//////////////////////////////////////////////////////////////////////

	// Combinational reads at the presented address
	assign xIn   = xMem[xReq];
	assign winIn = winMem[xReq];
	assign yIn   = yMem[yReadReq];

	always @(posedge mclk) begin
		if (yWrite === 1'b1)
			yMem[yWriteReq] <= yOut;
	end

	autoCorr dut (
		.mclk (mclk), .rstN (rstN), .ready (ready),
		.xIn (xIn), .winIn (winIn), .yIn (yIn),
		.xReq (xReq), .yReadReq (yReadReq), .yWriteReq (yWriteReq),
		.yOut (yOut), .yWrite (yWrite),
		.rReq (rReq), .rOut (rOut), .rWrite (rWrite), .done (done)
	);

	acChecker chk (
		.mclk (mclk), .rstN (rstN), .ready (ready),
		.xArr (xMem), .winArr (winMem),
		.xReq (xReq), .yReadReq (yReadReq),
		.yWriteReq (yWriteReq), .yOut (yOut), .yWrite (yWrite),
		.rReq (rReq), .rOut (rOut), .rWrite (rWrite), .done (done)
	);

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Address-dependent start contents, stale y shows up as a mismatch
	task automatic fillMemories();
		int i;
		for (i = 0; i < frameLen; i++) begin
			xMem[i]   = sampleT'(16'h4000 ^ (i * 16'h0101));
			winMem[i] = sampleT'(16'h2000 + i * 16'h0013);
			yMem[i]   = sampleT'(16'hA5A5 ^ (i * 16'h0203));
		end
	endtask

	task automatic loadFrame(input int kind);
		int i;
		for (i = 0; i < frameLen; i++) begin
			case (kind)
				kindSat: begin
					xMem[i]   = sampleMin;
					winMem[i] = sampleMin;
				end
				kindZero: begin
					xMem[i]   = '0;
					winMem[i] = '0;
				end
				default: begin
					// Small x keeps r[0] clear of saturation
					xMem[i]   = sampleT'($random(seed) % 4096);
					winMem[i] = sampleT'($random(seed) & 32'h7FFF);
				end
			endcase
		end
	endtask

	task automatic pulseReady();
		ready = 1'b1;
		@(posedge mclk);
		#1 ready = 1'b0;
	endtask

	// One frame, optional ready pulses in both phases
	task automatic runFrame(input int kind, input bit midReady);
		@(posedge mclk);
		#1 loadFrame(kind);
		pulseReady();
		if (midReady) begin
			repeat (100) @(posedge mclk);
			#1 pulseReady();
			repeat (200) @(posedge mclk);
			#1 pulseReady();
		end
		do
			@(negedge mclk);
		while (done !== 1'b1);
		repeat (3) @(posedge mclk);
	endtask

	initial begin
		rstN  = 1'b0;
		ready = 1'b0;
		seed  = 32'h7117;
		fillMemories();
		repeat (resetCycles) @(posedge mclk);
		#1 rstN = 1'b1;
		// No strobe may rise without ready
		repeat (quietCycles) @(posedge mclk);
		runFrame(kindRandom, 1'b0);
		runFrame(kindSat, 1'b0);
		runFrame(kindRandom, 1'b1);
		// Zero frame straight after a random one
		runFrame(kindZero, 1'b0);
		runFrame(kindRandom, 1'b0);
		runFrame(kindZero, 1'b0);
		repeat (5) @(posedge mclk);
		chk.finalCheck(numFrames, runOk);
		if (runOk)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	always @(posedge mclk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout after %0d cycles, done never arrived", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

//--- all.f
acPkg.sv
windowUnit.sv
lagFeeder.sv
lagCorrelator.sv
resultDrain.sv
autoCorr.sv
acChecker.sv
tbAutoCorr.sv

//--- Bender.yml
package:
  name: autoCorr

sources:
  - files:
      - acPkg.sv
      - windowUnit.sv
      - lagFeeder.sv
      - lagCorrelator.sv
      - resultDrain.sv
      - autoCorr.sv
  - target: test
    files:
      - acChecker.sv
      - tbAutoCorr.sv
